// File: cpu_pkg.sv
package cpu_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    // data path, pc and memory addresses share one width
    localparam int data_w     = 8;
    localparam int instr_w    = 32;
    localparam int reg_addr_w = 3;
    localparam int reg_count  = 1 << reg_addr_w;
    // rom covers the whole pc range
    localparam int rom_depth  = 1 << data_w;
    localparam int ram_depth  = 64;
    localparam int ram_addr_w = $clog2(ram_depth);

    typedef logic [data_w-1:0]     data_t;
    typedef logic [instr_w-1:0]    instr_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // ----------------------------------------
    // memory map
    // ----------------------------------------
    // load from here returns the switches
    localparam data_t in_port_addr  = 8'd255;
    // store here goes to the output port, not ram
    localparam data_t out_port_addr = 8'd254;

    // ----------------------------------------
    // encodings
    // ----------------------------------------
    typedef enum logic [5:0] {
        op_rtype = 6'd0,
        op_j     = 6'd2,
        op_beq   = 6'd4,
        op_addi  = 6'd8,
        op_lw    = 6'd35,
        op_sw    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'd32,
        fn_sub = 6'd34,
        fn_and = 6'd36,
        fn_or  = 6'd37,
        fn_slt = 6'd42
    } funct_e;

    // mips style alu control codes
    typedef enum logic [2:0] {
        alu_and = 3'b000,
        alu_or  = 3'b001,
        alu_add = 3'b010,
        alu_sub = 3'b110,
        alu_slt = 3'b111
    } alu_op_e;

endpackage

// File: pc_unit.sv
`timescale 1ns/1ns

module pc_unit (
    input  logic           clk,
    input  logic           reset,
    input  logic           branch,
    input  logic           zero,
    input  logic           jump,
    input  cpu_pkg::data_t imm,
    output cpu_pkg::data_t pc
);
    import cpu_pkg::*;

    data_t pc_plus1;
    data_t pc_branch;
    data_t pc_seq;
    data_t pc_next;
    logic  take_branch;

    // adders, both wrap modulo 256
    assign pc_plus1  = pc + data_t'(1);
    // branch offset is relative to pc+1
    assign pc_branch = pc_plus1 + imm;

    // beq taken only when the alu saw equal operands
    assign take_branch = branch & zero;
    assign pc_seq      = take_branch ? pc_branch : pc_plus1;
    // jump target is absolute
    assign pc_next     = jump ? imm : pc_seq;

    // ----------------------------------------
    // pc register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

// File: instr_rom.sv
`timescale 1ns/1ns

module instr_rom (
    input  cpu_pkg::data_t  pc,
    output cpu_pkg::instr_t instr
);
    import cpu_pkg::*;

    instr_t rom [rom_depth];

    // unused words stay zero, which decodes as a no-op
    initial begin
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = '0;
        end
        $readmemh("program.hex", rom);
    end

    // asynchronous read, same cycle as the pc
    assign instr = rom[pc];

endmodule

// File: control_unit.sv
`timescale 1ns/1ns

module control_unit (
    input  cpu_pkg::opcode_e opcode,
    input  cpu_pkg::funct_e  funct,
    output logic             reg_write,
    output logic             reg_dst,
    output logic             alu_src,
    output logic             mem_to_reg,
    output logic             mem_write,
    output logic             branch,
    output logic             jump,
    output cpu_pkg::alu_op_e alu_op
);
    import cpu_pkg::*;

    always_comb begin
        // defaults: nothing written, pc runs sequentially
        reg_write  = 1'b0;
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_op     = alu_add;

        case (opcode)
            op_rtype: begin
                // rd is the destination, op from funct
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    // unknown funct, so an all-zero word does nothing
                    default: reg_write = 1'b0;
                endcase
            end
            op_lw: begin
                // address = rs + imm, data back from memory
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_sw: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            op_addi: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            op_beq: begin
                // equal operands give a zero difference
                branch = 1'b1;
                alu_op = alu_sub;
            end
            op_j: begin
                jump = 1'b1;
            end
            default: begin
                // unknown opcode falls through as a no-op
                reg_write = 1'b0;
            end
        endcase
    end

endmodule

// File: register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t ra2,
    input  cpu_pkg::reg_addr_t wa3,
    input  logic               we3,
    input  cpu_pkg::data_t     wd3,
    output cpu_pkg::data_t     rd1,
    output cpu_pkg::data_t     rd2
);
    import cpu_pkg::*;

    data_t regs [reg_count];

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we3 && (wa3 != '0)) begin
            // r0 is hardwired, writes to it are dropped
            regs[wa3] <= wd3;
        end
    end

    // ----------------------------------------
    // read ports
    // ----------------------------------------
    // combinational, r0 forced to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::data_t   src_a,
    input  cpu_pkg::data_t   src_b,
    input  cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::data_t   result,
    output logic             zero
);
    import cpu_pkg::*;

    always_comb begin
        case (alu_op)
            alu_and: result = src_a & src_b;
            alu_or:  result = src_a | src_b;
            // add and sub wrap modulo 256
            alu_add: result = src_a + src_b;
            alu_sub: result = src_a - src_b;
            // unsigned compare, result is 1 or 0
            alu_slt: result = (src_a < src_b) ? data_t'(1) : '0;
            default: result = '0;
        endcase
    end

    // zero flag feeds the beq decision
    assign zero = (result == '0);

endmodule

// File: data_mem_io.sv
`timescale 1ns/1ns

module data_mem_io (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::data_t address,
    input  cpu_pkg::data_t write_data,
    input  logic           mem_write,
    input  cpu_pkg::data_t switches,
    output cpu_pkg::data_t read_data,
    output cpu_pkg::data_t parallel_out
);
    import cpu_pkg::*;

    data_t                 ram [ram_depth];
    logic [ram_addr_w-1:0] ram_index;
    logic                  sel_in_port;
    logic                  sel_out_port;

    // ram only sees the low address bits
    assign ram_index = address[ram_addr_w-1:0];

    // address decode for the two io ports
    assign sel_in_port  = (address == in_port_addr);
    assign sel_out_port = (address == out_port_addr);

    // ----------------------------------------
    // data ram
    // ----------------------------------------
    // store to the output port never reaches ram
    always_ff @(posedge clk) begin
        if (!reset && mem_write && !sel_out_port) begin
            ram[ram_index] <= write_data;
        end
    end

    // ----------------------------------------
    // parallel output port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            parallel_out <= '0;
        end else if (mem_write && sel_out_port) begin
            parallel_out <= write_data;
        end
    end

    // read mux: switches at the input port, ram elsewhere
    assign read_data = sel_in_port ? switches : ram[ram_index];

endmodule

// File: mips8_top.sv
`timescale 1ns/1ns

module mips8_top (
    input  logic           clk,
    input  logic           reset,
    input  cpu_pkg::data_t switches,
    output cpu_pkg::data_t parallel_out
);
    import cpu_pkg::*;

    data_t     pc;
    instr_t    instr;
    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    data_t     imm;
    logic      reg_write;
    logic      reg_dst;
    logic      alu_src;
    logic      mem_to_reg;
    logic      mem_write;
    logic      branch;
    logic      jump;
    alu_op_e   alu_op;
    reg_addr_t wa3;
    data_t     rd1;
    data_t     rd2;
    data_t     src_b;
    data_t     result;
    logic      zero;
    data_t     read_data;
    data_t     wd3;

    // ----------------------------------------
    // instruction fields
    // ----------------------------------------
    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    // only eight registers, low bits of each 5-bit field
    assign rs     = instr[21 +: reg_addr_w];
    assign rt     = instr[16 +: reg_addr_w];
    assign rd     = instr[11 +: reg_addr_w];
    // immediate and jump target share the low byte
    assign imm    = instr[data_w-1:0];

    // ----------------------------------------
    // datapath muxes
    // ----------------------------------------
    assign wa3   = reg_dst ? rd : rt;
    assign src_b = alu_src ? imm : rd2;
    assign wd3   = mem_to_reg ? read_data : result;

    pc_unit i_pc_unit (
        .clk    (clk),
        .reset  (reset),
        .branch (branch),
        .zero   (zero),
        .jump   (jump),
        .imm    (imm),
        .pc     (pc)
    );

    instr_rom i_instr_rom (
        .pc    (pc),
        .instr (instr)
    );

    control_unit i_control_unit (
        .opcode     (opcode),
        .funct      (funct),
        .reg_write  (reg_write),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .alu_op     (alu_op)
    );

    register_file i_register_file (
        .clk   (clk),
        .reset (reset),
        .ra1   (rs),
        .ra2   (rt),
        .wa3   (wa3),
        .we3   (reg_write),
        .wd3   (wd3),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    alu i_alu (
        .src_a  (rd1),
        .src_b  (src_b),
        .alu_op (alu_op),
        .result (result),
        .zero   (zero)
    );

    // alu result doubles as the memory address
    data_mem_io i_data_mem_io (
        .clk          (clk),
        .reset        (reset),
        .address      (result),
        .write_data   (rd2),
        .mem_write    (mem_write),
        .switches     (switches),
        .read_data    (read_data),
        .parallel_out (parallel_out)
    );

endmodule

// File: mips8_sva.sv
`timescale 1ns/1ns

module mips8_sva (
    input logic           clk,
    input logic           reset,
    input cpu_pkg::data_t pc,
    input logic           reg_write,
    input logic           mem_write,
    input cpu_pkg::data_t result,
    input cpu_pkg::data_t parallel_out
);
    import cpu_pkg::*;

    // pc restarts at 0 the cycle after reset
    pc_after_reset: assert property (@(posedge clk) reset |=> (pc == '0))
        else $error("pc not zero after reset");

    // no instruction writes both a register and memory
    single_write: assert property (@(posedge clk) disable iff (reset)
        !(reg_write && mem_write))
        else $error("reg_write and mem_write high together");

    // output port moves only after a store to its address
    out_port_store: assert property (@(posedge clk) disable iff (reset)
        $changed(parallel_out) |-> $past(mem_write && (result == out_port_addr)))
        else $error("parallel_out changed without a store to the output port");

endmodule

bind mips8_top mips8_sva i_sva (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .reg_write    (reg_write),
    .mem_write    (mem_write),
    .result       (result),
    .parallel_out (parallel_out)
);

// File: tb_mips8.sv
`timescale 1ns/1ns

module tb_mips8;
    import cpu_pkg::*;

    // ----------------------------------------
    // run constants
    // ----------------------------------------
    localparam int clk_period   = 40;
    localparam int drive_delay  = 1;
    localparam int reset_cycles = 5;
    // two full program loops fit in this
    localparam int hold_cycles  = 30;
    localparam int n_vectors    = 9;
    // address of the store to the output port in program.hex
    localparam int store_pc     = 10;
    // table plus one extra hold, plus reset and startup, doubled
    localparam int watchdog_ns  =
        2 * ((n_vectors + 1) * hold_cycles * clk_period
             + (reset_cycles + store_pc + 1) * clk_period);

    logic  clk;
    logic  reset;
    data_t switches;
    data_t parallel_out;

    // {switch value, expected parallel_out}
    logic [15:0] vectors [n_vectors];

    mips8_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .switches     (switches),
        .parallel_out (parallel_out)
    );

    always #(clk_period / 2) clk = ~clk;

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    // out = (a < 5 ? 5 - a : a + 5) | (a & 5), all mod 256
    task automatic load_vectors();
        // below 5, subtract path
        vectors[0] = {8'h00, 8'h05};
        vectors[1] = {8'h03, 8'h03};
        vectors[2] = {8'h04, 8'h05};
        // 5 and up, add plus ram round trip
        vectors[3] = {8'h05, 8'h0F};
        vectors[4] = {8'h09, 8'h0F};
        vectors[5] = {8'h5A, 8'h5F};
        vectors[6] = {8'h80, 8'h85};
        // add wraps past 255
        vectors[7] = {8'hFB, 8'h01};
        vectors[8] = {8'hFF, 8'h05};
    endtask

    // compare the output port with the expected value
    task automatic expect_output(input data_t expected, input string phase);
        assert (parallel_out === expected) else begin
            $display("FAILED at %0t ns: %s, switches 0x%02h, expected 0x%02h, got 0x%02h",
                     $time, phase, switches, expected, parallel_out);
            $display("sim failed");
            $fatal(1, "output port mismatch");
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        data_t last_expected;

        clk      = 1'b0;
        reset    = 1'b1;
        switches = '0;
        load_vectors();
        last_expected = '0;

        // output register must read zero through reset
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            #drive_delay;
            expect_output(8'h00, "during reset");
        end
        reset = 1'b0;
        // no earlier instruction may touch the port before the store lands
        for (int i = 0; i <= store_pc; i++) begin
            @(negedge clk);
            expect_output(8'h00, "before first store");
        end

        for (int i = 0; i < n_vectors; i++) begin
            @(posedge clk);
            #drive_delay;
            switches = vectors[i][15:8];
            repeat (hold_cycles) @(posedge clk);
            // sample mid-cycle, away from the edge
            @(negedge clk);
            expect_output(vectors[i][7:0], "table entry");
            last_expected = vectors[i][7:0];
        end

        // same input again, jump back and re-read must not disturb it
        repeat (hold_cycles) @(posedge clk);
        @(negedge clk);
        expect_output(last_expected, "extra hold");

        $display("sim passed");
        $finish;
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        #(watchdog_ns);
        $display("watchdog timeout, program output never settled");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: program.hex
// one 32-bit instruction word per line, address 0 upward
8C0100FF
20020005
00221820
AC030010
8C040010
0022282A
10A00001
00412022
00223024
00863825
AC0700FE
08000000

// File: src.f
cpu_pkg.sv
pc_unit.sv
instr_rom.sv
control_unit.sv
register_file.sv
alu.sv
data_mem_io.sv
mips8_top.sv
mips8_sva.sv
tb_mips8.sv

// File: Bender.yml
package:
  name: mips8

sources:
  - cpu_pkg.sv
  - pc_unit.sv
  - instr_rom.sv
  - control_unit.sv
  - register_file.sv
  - alu.sv
  - data_mem_io.sv
  - mips8_top.sv
  - target: test
    files:
      - mips8_sva.sv
      - tb_mips8.sv
